// File: rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int NUM_REGS   = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t PC_RESET = 32'h2040_0000;   // first fetch after reset

    // major opcodes of the kept RV32I subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011
    } opcode_e;

    typedef enum logic [2:0] {
        CLS_ALU,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_NONE
    } instr_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // encoded as the branch funct3
    typedef enum logic [2:0] {
        BR_BEQ  = 3'b000,
        BR_BNE  = 3'b001,
        BR_BLT  = 3'b100,
        BR_BGE  = 3'b101,
        BR_BLTU = 3'b110,
        BR_BGEU = 3'b111
    } branch_e;

    typedef enum logic [2:0] {
        ST_FETCH,
        ST_DECODE,
        ST_OPERAND,
        ST_EXECUTE,
        ST_LOAD,
        ST_WRITEBACK
    } stage_e;

endpackage

// File: rv_bus_master.sv
module rv_bus_master
    import rv_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,

    input  logic  i_req,
    input  word_t i_addr,
    output logic  o_done,
    output word_t o_rdata,

    input  logic  i_ack,
    input  logic  i_stall,
    input  word_t i_data,
    output logic  o_cyc,
    output logic  o_stb,
    output word_t o_addr
);

    logic  req_pend;
    word_t req_addr;
    logic  start;
    logic  finish;

    assign start  = req_pend && !o_cyc && !i_stall;   // idle and slave not stalling
    assign finish = o_cyc && i_ack && !i_stall;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            req_pend <= 1'b0;
            o_cyc    <= 1'b0;
            o_stb    <= 1'b0;
            o_addr   <= '0;
            o_done   <= 1'b0;
        end else begin
            o_stb  <= 1'b0;   // strobe lasts a single cycle
            o_done <= 1'b0;
            if (i_req) begin
                req_pend <= 1'b1;
            end
            if (start) begin
                req_pend <= 1'b0;
                o_stb    <= 1'b1;
                o_cyc    <= 1'b1;
                o_addr   <= req_addr;
            end
            if (finish) begin
                o_cyc  <= 1'b0;
                o_addr <= '0;
                o_done <= 1'b1;   // one cycle after the accepted ack
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_req) begin
            req_addr <= i_addr;
        end
        if (finish) begin
            o_rdata <= i_data;   // held until the next completion
        end
    end

endmodule

// File: rv_decoder.sv
module rv_decoder
    import rv_pkg::*;
(
    input  word_t        i_instr,
    output reg_addr_t    o_rs1,
    output reg_addr_t    o_rs2,
    output reg_addr_t    o_rd,
    output word_t        o_imm,
    output instr_class_e o_class,
    output alu_op_e      o_alu_op,
    output branch_e      o_branch,
    output logic         o_a_is_pc,
    output logic         o_b_is_imm
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       is_op;
    logic       f7_base;
    logic       f7_alt;
    word_t      imm_i;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_sh;

    assign opcode  = opcode_e'(i_instr[6:0]);
    assign funct3  = i_instr[14:12];
    assign funct7  = i_instr[31:25];
    assign is_op   = (opcode == OPC_OP);
    assign f7_base = (funct7 == 7'b0000000);
    assign f7_alt  = (funct7 == 7'b0100000);   // sub and sra

    assign o_rs1    = i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_rd     = i_instr[11:7];
    assign o_branch = branch_e'(funct3);

    assign imm_i  = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_b  = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u  = {i_instr[31:12], 12'b0};
    assign imm_j  = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};
    assign imm_sh = {{(XLEN-5){1'b0}}, i_instr[24:20]};

    always_comb begin
        o_class    = CLS_NONE;
        o_alu_op   = ALU_ADD;
        o_imm      = imm_i;
        o_a_is_pc  = 1'b0;
        o_b_is_imm = 1'b1;
        case (opcode)
            OPC_LUI: begin
                o_class = CLS_LUI;
                o_imm   = imm_u;
            end
            OPC_AUIPC: begin
                o_class   = CLS_AUIPC;
                o_imm     = imm_u;
                o_a_is_pc = 1'b1;
            end
            OPC_JAL: begin
                o_class   = CLS_JAL;
                o_imm     = imm_j;
                o_a_is_pc = 1'b1;   // target is pc + offset
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    o_class = CLS_JALR;
                end
            end
            OPC_BRANCH: begin
                o_imm     = imm_b;
                o_a_is_pc = 1'b1;
                if (funct3[2:1] != 2'b01) begin   // 010 and 011 are reserved
                    o_class = CLS_BRANCH;
                end
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin   // lw only
                    o_class = CLS_LOAD;
                end
            end
            OPC_OP_IMM, OPC_OP: begin
                o_class    = CLS_ALU;
                o_b_is_imm = !is_op;
                case (funct3)
                    3'b000:  o_alu_op = (is_op && f7_alt) ? ALU_SUB : ALU_ADD;
                    3'b001:  o_alu_op = ALU_SLL;
                    3'b010:  o_alu_op = ALU_SLT;
                    3'b011:  o_alu_op = ALU_SLTU;
                    3'b100:  o_alu_op = ALU_XOR;
                    3'b101:  o_alu_op = f7_alt ? ALU_SRA : ALU_SRL;
                    3'b110:  o_alu_op = ALU_OR;
                    default: o_alu_op = ALU_AND;
                endcase
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    if (!is_op) begin
                        o_imm = imm_sh;
                    end
                    if (!(f7_base || (f7_alt && funct3 == 3'b101))) begin
                        o_class = CLS_NONE;
                    end
                end else if (is_op && !(f7_base || (f7_alt && funct3 == 3'b000))) begin
                    o_class = CLS_NONE;
                end
            end
            default: o_class = CLS_NONE;
        endcase
    end

endmodule

// File: rv_regfile.sv
module rv_regfile
    import rv_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  reg_addr_t i_raddr_a,
    input  reg_addr_t i_raddr_b,
    output word_t     o_rdata_a,
    output word_t     o_rdata_b,
    input  logic      i_we,
    input  reg_addr_t i_waddr,
    input  word_t     i_wdata
);

    word_t regs [NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            regs <= '{default: '0};
        end else if (i_we && i_waddr != '0) begin   // x0 stays zero
            regs[i_waddr] <= i_wdata;
        end
    end

    assign o_rdata_a = regs[i_raddr_a];
    assign o_rdata_b = regs[i_raddr_b];

endmodule

// File: rv_alu.sv
module rv_alu
    import rv_pkg::*;
(
    input  word_t   i_a,
    input  word_t   i_b,
    input  alu_op_e i_op,
    input  word_t   i_cmp_a,
    input  word_t   i_cmp_b,
    input  branch_e i_branch,
    output word_t   o_result,
    output logic    o_taken
);

    logic [4:0] shamt;
    logic       cmp_eq;
    logic       cmp_lt;
    logic       cmp_ltu;

    assign shamt = i_b[4:0];   // only the low 5 bits shift

    always_comb begin
        case (i_op)
            ALU_ADD:  o_result = i_a + i_b;
            ALU_SUB:  o_result = i_a - i_b;
            ALU_SLL:  o_result = i_a << shamt;
            ALU_SLT:  o_result = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
            ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, i_a < i_b};
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_SRL:  o_result = i_a >> shamt;
            ALU_SRA:  o_result = word_t'($signed(i_a) >>> shamt);
            ALU_OR:   o_result = i_a | i_b;
            ALU_AND:  o_result = i_a & i_b;
            default:  o_result = '0;
        endcase
    end

    // branch compare works on the raw register values
    assign cmp_eq  = (i_cmp_a == i_cmp_b);
    assign cmp_lt  = ($signed(i_cmp_a) < $signed(i_cmp_b));
    assign cmp_ltu = (i_cmp_a < i_cmp_b);

    always_comb begin
        case (i_branch)
            BR_BEQ:  o_taken = cmp_eq;
            BR_BNE:  o_taken = !cmp_eq;
            BR_BLT:  o_taken = cmp_lt;
            BR_BGE:  o_taken = !cmp_lt;
            BR_BLTU: o_taken = cmp_ltu;
            BR_BGEU: o_taken = !cmp_ltu;
            default: o_taken = 1'b0;
        endcase
    end

endmodule

// File: rv_control.sv
module rv_control
    import rv_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,

    output logic         o_bus_req,
    output word_t        o_bus_addr,
    input  logic         i_bus_done,
    input  word_t        i_bus_rdata,

    output word_t        o_instr,
    input  reg_addr_t    i_rs1,
    input  reg_addr_t    i_rs2,
    input  reg_addr_t    i_rd,
    input  word_t        i_imm,
    input  instr_class_e i_class,
    input  alu_op_e      i_alu_op,
    input  branch_e      i_branch,
    input  logic         i_a_is_pc,
    input  logic         i_b_is_imm,

    output reg_addr_t    o_raddr_a,
    output reg_addr_t    o_raddr_b,
    input  word_t        i_rdata_a,
    input  word_t        i_rdata_b,
    output logic         o_we,
    output reg_addr_t    o_waddr,
    output word_t        o_wdata,

    output word_t        o_alu_a,
    output word_t        o_alu_b,
    output alu_op_e      o_alu_op,
    output word_t        o_cmp_a,
    output word_t        o_cmp_b,
    output branch_e      o_branch,
    input  word_t        i_alu_result,
    input  logic         i_taken
);

    stage_e       stage;
    word_t        pc;
    logic         fetch_sent;
    word_t        instr_q;
    reg_addr_t    rs1_q;
    reg_addr_t    rs2_q;
    reg_addr_t    rd_q;
    word_t        imm_q;
    instr_class_e class_q;
    alu_op_e      alu_op_q;
    branch_e      branch_q;
    logic         a_is_pc_q;
    logic         b_is_imm_q;
    word_t        op_a;
    word_t        op_b;
    word_t        cmp_a;
    word_t        cmp_b;
    word_t        result_q;
    logic         taken_q;
    word_t        pc_plus4;
    word_t        load_addr;
    word_t        next_pc;

    assign pc_plus4  = pc + 32'd4;
    assign load_addr = i_rdata_a + imm_q;   // issued straight from the operand cycle

    assign o_bus_req  = (stage == ST_FETCH && !fetch_sent) ||
                        (stage == ST_OPERAND && class_q == CLS_LOAD);
    assign o_bus_addr = (stage == ST_FETCH) ? pc : load_addr;

    assign o_instr   = instr_q;
    assign o_raddr_a = rs1_q;
    assign o_raddr_b = rs2_q;
    assign o_waddr   = rd_q;
    assign o_alu_a   = op_a;
    assign o_alu_b   = op_b;
    assign o_alu_op  = alu_op_q;
    assign o_cmp_a   = cmp_a;
    assign o_cmp_b   = cmp_b;
    assign o_branch  = branch_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage      <= ST_FETCH;
            pc         <= PC_RESET;
            fetch_sent <= 1'b0;
            class_q    <= CLS_NONE;
        end else begin
            case (stage)
                ST_FETCH: begin
                    fetch_sent <= !i_bus_done;
                    if (i_bus_done) begin
                        stage <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    class_q <= i_class;
                    stage   <= ST_OPERAND;
                end
                ST_OPERAND:   stage <= (class_q == CLS_LOAD) ? ST_LOAD : ST_EXECUTE;
                ST_EXECUTE:   stage <= ST_WRITEBACK;
                ST_LOAD: begin
                    if (i_bus_done) begin
                        pc    <= pc_plus4;
                        stage <= ST_FETCH;
                    end
                end
                ST_WRITEBACK: begin
                    pc    <= next_pc;
                    stage <= ST_FETCH;
                end
                default:      stage <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (stage == ST_FETCH && i_bus_done) begin
            instr_q <= i_bus_rdata;
        end
        if (stage == ST_DECODE) begin
            rs1_q      <= i_rs1;
            rs2_q      <= i_rs2;
            rd_q       <= i_rd;
            imm_q      <= i_imm;
            alu_op_q   <= i_alu_op;
            branch_q   <= i_branch;
            a_is_pc_q  <= i_a_is_pc;
            b_is_imm_q <= i_b_is_imm;
        end
        if (stage == ST_OPERAND) begin
            op_a  <= a_is_pc_q ? pc : i_rdata_a;
            op_b  <= b_is_imm_q ? imm_q : i_rdata_b;
            cmp_a <= i_rdata_a;
            cmp_b <= i_rdata_b;
        end
        if (stage == ST_EXECUTE) begin
            result_q <= i_alu_result;
            taken_q  <= i_taken;
        end
    end

    always_comb begin
        o_we    = 1'b0;
        o_wdata = result_q;
        if (stage == ST_LOAD) begin
            o_we    = i_bus_done;   // load data lands as the read completes
            o_wdata = i_bus_rdata;
        end else if (stage == ST_WRITEBACK) begin
            case (class_q)
                CLS_ALU, CLS_AUIPC: o_we = 1'b1;
                CLS_LUI: begin
                    o_we    = 1'b1;
                    o_wdata = imm_q;
                end
                CLS_JAL, CLS_JALR: begin
                    o_we    = 1'b1;
                    o_wdata = pc_plus4;   // link value
                end
                default: o_we = 1'b0;
            endcase
        end
    end

    always_comb begin
        case (class_q)
            CLS_JAL:    next_pc = result_q;
            CLS_JALR:   next_pc = {result_q[XLEN-1:1], 1'b0};
            CLS_BRANCH: next_pc = taken_q ? result_q : pc_plus4;
            default:    next_pc = pc_plus4;
        endcase
    end

endmodule

// File: rv_core_top.sv
module rv_core_top
    import rv_pkg::*;
(
    input  logic  i_clk,
    input  logic  i_rst,
    input  logic  i_ack,
    input  logic  i_stall,
    input  word_t i_data,
    output logic  o_cyc,
    output logic  o_stb,
    output word_t o_addr
);

    logic         bus_req;
    word_t        bus_addr;
    logic         bus_done;
    word_t        bus_rdata;

    word_t        instr;
    reg_addr_t    dec_rs1;
    reg_addr_t    dec_rs2;
    reg_addr_t    dec_rd;
    word_t        dec_imm;
    instr_class_e dec_class;
    alu_op_e      dec_alu_op;
    branch_e      dec_branch;
    logic         dec_a_is_pc;
    logic         dec_b_is_imm;

    reg_addr_t    raddr_a;
    reg_addr_t    raddr_b;
    word_t        rdata_a;
    word_t        rdata_b;
    logic         we;
    reg_addr_t    waddr;
    word_t        wdata;

    word_t        alu_a;
    word_t        alu_b;
    alu_op_e      alu_op;
    word_t        cmp_a;
    word_t        cmp_b;
    branch_e      branch;
    word_t        alu_result;
    logic         taken;

    rv_control u_control (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .o_bus_req    (bus_req),
        .o_bus_addr   (bus_addr),
        .i_bus_done   (bus_done),
        .i_bus_rdata  (bus_rdata),
        .o_instr      (instr),
        .i_rs1        (dec_rs1),
        .i_rs2        (dec_rs2),
        .i_rd         (dec_rd),
        .i_imm        (dec_imm),
        .i_class      (dec_class),
        .i_alu_op     (dec_alu_op),
        .i_branch     (dec_branch),
        .i_a_is_pc    (dec_a_is_pc),
        .i_b_is_imm   (dec_b_is_imm),
        .o_raddr_a    (raddr_a),
        .o_raddr_b    (raddr_b),
        .i_rdata_a    (rdata_a),
        .i_rdata_b    (rdata_b),
        .o_we         (we),
        .o_waddr      (waddr),
        .o_wdata      (wdata),
        .o_alu_a      (alu_a),
        .o_alu_b      (alu_b),
        .o_alu_op     (alu_op),
        .o_cmp_a      (cmp_a),
        .o_cmp_b      (cmp_b),
        .o_branch     (branch),
        .i_alu_result (alu_result),
        .i_taken      (taken)
    );

    rv_decoder u_decoder (
        .i_instr    (instr),
        .o_rs1      (dec_rs1),
        .o_rs2      (dec_rs2),
        .o_rd       (dec_rd),
        .o_imm      (dec_imm),
        .o_class    (dec_class),
        .o_alu_op   (dec_alu_op),
        .o_branch   (dec_branch),
        .o_a_is_pc  (dec_a_is_pc),
        .o_b_is_imm (dec_b_is_imm)
    );

    rv_regfile u_regfile (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_raddr_a (raddr_a),
        .i_raddr_b (raddr_b),
        .o_rdata_a (rdata_a),
        .o_rdata_b (rdata_b),
        .i_we      (we),
        .i_waddr   (waddr),
        .i_wdata   (wdata)
    );

    rv_alu u_alu (
        .i_a      (alu_a),
        .i_b      (alu_b),
        .i_op     (alu_op),
        .i_cmp_a  (cmp_a),
        .i_cmp_b  (cmp_b),
        .i_branch (branch),
        .o_result (alu_result),
        .o_taken  (taken)
    );

    rv_bus_master u_bus_master (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_req   (bus_req),
        .i_addr  (bus_addr),
        .o_done  (bus_done),
        .o_rdata (bus_rdata),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr)
    );

endmodule

// File: rv_core_checker.sv
module rv_core_checker (
    input logic i_clk,
    input logic i_rst,
    input logic i_cyc,
    input logic i_stb
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    a_stb_single: assert property (@(posedge i_clk) disable iff (i_rst) i_stb |=> !i_stb)
        else begin
            fail_count++;
            $error("o_stb high in two cycles in a row");
        end

    a_stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst) i_stb |-> i_cyc)
        else begin
            fail_count++;
            $error("o_stb high while o_cyc is low");
        end

    // bus is idle one cycle after any reset cycle
    a_reset_idle: assert property (@(posedge i_clk) i_rst |=> (!i_cyc && !i_stb))
        else begin
            fail_count++;
            $error("bus not idle after reset");
        end

endmodule

bind rv_core_top rv_core_checker u_checker (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_cyc (o_cyc),
    .i_stb (o_stb)
);

// File: tb_rv_core.sv
module tb_rv_core
    import rv_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int WIN = 64;   // program window in words from PC_RESET
    localparam int TEST_LEN [5] = '{1, 200, 200, 200, 400};
    localparam int NUM_INSTR = TEST_LEN[0] + TEST_LEN[1] + TEST_LEN[2] + TEST_LEN[3] + TEST_LEN[4];
    localparam int TIMEOUT_NS = NUM_INSTR * 6 * 8 * 20 + 2000;

    // weights per test for kinds: op, op-imm, lui, auipc, branch, jal, jalr, lw
    localparam int unsigned MIX [5][8] = '{
        '{15, 15, 10, 10, 20, 10, 10, 10},
        '{35, 35, 10, 10,  0,  0,  0, 10},
        '{10, 10,  0, 10, 40, 10, 10, 10},
        '{20, 20, 10,  0,  0,  0,  0, 50},
        '{15, 15, 10, 10, 20, 10, 10, 10}
    };

    logic  i_clk = 1'b0;
    logic  i_rst;
    logic  i_ack;
    logic  i_stall;
    word_t i_data;
    logic  o_cyc;
    logic  o_stb;
    word_t o_addr;

    int          seed;
    int unsigned errors = 0;
    int unsigned accesses = 0;
    word_t       regs [NUM_REGS];   // reference model state
    word_t       pc;
    string       test_name [5] = '{"reset vector", "alu stream", "branch and jump stream",
                                   "load stream", "mixed stream"};

    rv_core_top u_dut (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_ack   (i_ack),
        .i_stall (i_stall),
        .i_data  (i_data),
        .o_cyc   (o_cyc),
        .o_stb   (o_stb),
        .o_addr  (o_addr)
    );

    always #10 i_clk = ~i_clk;

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check(input word_t exp, input word_t act, input string msg);
        if (act !== exp) begin
            errors++;
            $display("MISMATCH at %0t ns: %s expected %08h got %08h", $time, msg, exp, act);
        end
    endtask

    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // next instruction of the random stream, targets kept inside the window
    function automatic word_t gen_instr(input int mode);
        int unsigned r;
        int unsigned kind;
        int unsigned start;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  cand;
        logic [2:0]  f3;
        logic [11:0] imm12;
        logic [12:0] boff;
        logic [20:0] joff;
        word_t       rw;
        word_t       tgt;
        word_t       diff;
        rd = 5'(rnd(32));
        rs1 = 5'(rnd(32));
        rs2 = (rnd(2) != 0) ? rs1 : 5'(rnd(32));   // equal operands make branches interesting
        f3 = 3'(rnd(8));
        imm12 = 12'(rnd(4096));
        rw = $random(seed);
        tgt = PC_RESET + 4 * rnd(WIN);
        r = rnd(100);
        kind = 0;
        while (r >= MIX[mode][kind]) begin
            r -= MIX[mode][kind];
            kind++;
        end
        if ((pc - PC_RESET) >> 2 >= WIN - 1) begin
            kind = 5;   // last slot jumps back
        end
        case (kind)
            0: return {((f3 == 3'b000 || f3 == 3'b101) && rnd(2) != 0) ? 7'h20 : 7'h00,
                       rs2, rs1, f3, rd, OPC_OP};
            1: begin
                if (f3 == 3'b001) begin
                    imm12[11:5] = 7'h00;
                end
                if (f3 == 3'b101) begin
                    imm12[11:5] = (rnd(2) != 0) ? 7'h20 : 7'h00;
                end
                return {imm12, rs1, f3, rd, OPC_OP_IMM};
            end
            2: return {rw[31:12], rd, OPC_LUI};
            3: return {(rnd(2) != 0) ? 20'h0 : rw[31:12], rd, OPC_AUIPC};
            4: begin
                if (f3[2:1] == 2'b01) begin
                    f3 = f3 ^ 3'b010;
                end
                boff = 13'(tgt - pc);
                return {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], OPC_BRANCH};
            end
            5: begin
                joff = 21'(tgt - pc);
                return {joff[20], joff[10:1], joff[11], joff[19:12], rd, OPC_JAL};
            end
            6: begin
                start = rnd(31);
                for (int i = 0; i < 31; i++) begin
                    cand = 5'(1 + (start + i) % 31);
                    diff = tgt - regs[cand];
                    if ($signed(diff) >= -2048 && $signed(diff) <= 2046) begin
                        imm12 = diff[11:0] + (regs[cand][0] ? 12'd0 : 12'(rnd(2)));
                        return {imm12, cand, 3'b000, rd, OPC_JALR};
                    end
                end
                return {20'h0, (rd == 5'd0) ? 5'd1 : rd, OPC_AUIPC};   // no base yet, make one
            end
            default: return {imm12, rs1, 3'b010, rd, OPC_LOAD};
        endcase
    endfunction

    // answers one bus access and checks its address
    task automatic serve(input word_t exp_addr, input word_t data, input string what);
        int unsigned run;
        int unsigned wait_ack;
        int unsigned hold;
        run = 0;
        wait_ack = 1 + rnd(3);
        hold = rnd(3);
        do begin
            i_stall = (run < 2) && (rnd(2) != 0);   // at most two stalled cycles in a row
            run = i_stall ? run + 1 : 0;
            @(negedge i_clk);
        end while (o_stb !== 1'b1);
        check('0, {31'b0, i_stall}, {what, " started under stall"});
        check(exp_addr, o_addr, what);
        accesses++;
        i_stall = 1'b0;
        repeat (wait_ack - 1) @(negedge i_clk);
        i_ack = 1'b1;
        repeat (hold) begin
            i_stall = 1'b1;   // stall holds off the ack
            i_data = ~data;
            @(negedge i_clk);
            check(32'd1, {31'b0, o_cyc}, {what, " held by stall"});
        end
        i_stall = 1'b0;
        i_data = data;
        @(negedge i_clk);
        i_ack = 1'b0;
        i_data = ~data;
        check('0, {31'b0, o_cyc}, {what, " cycle end"});
    endtask

    task automatic step(input int mode);
        word_t w;
        word_t a;
        word_t b;
        word_t imm_i;
        word_t val;
        word_t nxt;
        word_t data;
        w = gen_instr(mode);
        serve(pc, w, "fetch address");
        a = regs[w[19:15]];
        b = regs[w[24:20]];
        imm_i = {{20{w[31]}}, w[31:20]};
        val = pc + 4;   // link value unless replaced
        nxt = pc + 4;
        case (w[6:0])
            OPC_LUI:    val = {w[31:12], 12'h000};
            OPC_AUIPC:  val = pc + {w[31:12], 12'h000};
            OPC_JAL:    nxt = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            OPC_JALR:   nxt = (a + imm_i) & 32'hffff_fffe;
            OPC_BRANCH: begin
                if (branch_ref(w[14:12], a, b)) begin
                    nxt = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            OPC_OP_IMM: val = alu_ref(w[14:12], w[30] && w[14:12] == 3'b101, a, imm_i);
            OPC_OP:     val = alu_ref(w[14:12], w[30], a, b);
            OPC_LOAD: begin
                data = $random(seed);
                serve(a + imm_i, data, "load address");
                val = data;
            end
            default: val = pc + 4;
        endcase
        if (w[6:0] != OPC_BRANCH && w[11:7] != 5'd0) begin
            regs[w[11:7]] = val;
        end
        pc = nxt;
    endtask

    initial begin
        int unsigned err_start;
        seed = 32'h0465a3e8;
        i_rst = 1'b1;
        i_ack = 1'b0;
        i_stall = 1'b0;
        i_data = '0;
        pc = PC_RESET;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        repeat (4) @(negedge i_clk);
        i_rst = 1'b0;
        for (int t = 0; t < 5; t++) begin
            err_start = errors;
            repeat (TEST_LEN[t]) step(t);
            $display("test %0d %s: %0d instructions, %0d errors", t + 1, test_name[t],
                     TEST_LEN[t], errors - err_start);
        end
        errors += u_dut.u_checker.fail_count;
        $display("summary: %0d instructions, %0d bus accesses, %0d errors",
                 NUM_INSTR, accesses, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: compile.f
rv_pkg.sv
rv_bus_master.sv
rv_decoder.sv
rv_regfile.sv
rv_alu.sv
rv_control.sv
rv_core_top.sv
rv_core_checker.sv
tb_rv_core.sv
